// ==== flist.f ====
hdl/frame_pkg.sv
hdl/spi_peripheral.sv
hdl/spi_register.sv
hdl/display_registers.sv
hdl/display_timing.sv
hdl/top.sv
testbench/tb_top.sv

// ==== hdl/display_registers.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display configuration written over SPI: fill colour and enable.
// Also counts frames and returns the count on a read.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module display_registers import frame_pkg::*; (
    input  logic               clock,
    input  logic               reset,

    input  byte_t              opcode,
    input  logic               opcode_valid,
    input  byte_t              operand,
    input  logic               operand_valid,
    input  integer             operand_count,

    input  logic               frame_start,

    output logic [y_width-1:0] fill_y,
    output logic [c_width-1:0] fill_cb,
    output logic [c_width-1:0] fill_cr,
    output logic               display_enable,

    output byte_t              response,
    output logic               response_valid
);

    byte_t frame_count;  // Wraps at 256

    // Field writes, selected by operand index
    always_ff @(posedge clock) begin
        if (reset) begin
            fill_y         <= '0;
            fill_cb        <= '0;
            fill_cr        <= '0;
            display_enable <= 1'b0;
        end else if (opcode_valid && operand_valid) begin
            if (opcode == opcode_fill_colour) begin
                if (operand_count == 0) begin
                    fill_y <= operand[y_width-1:0];
                end else if (operand_count == 1) begin
                    fill_cb <= operand[c_width-1:0];
                end else if (operand_count == 2) begin
                    fill_cr <= operand[c_width-1:0];
                end
            end else if (opcode == opcode_display_enable && operand_count == 0) begin
                display_enable <= operand[0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            frame_count    <= '0;
            response_valid <= 1'b0;
        end else begin
            if (frame_start) begin
                frame_count <= frame_count + 1'b1;
            end
            response_valid <= opcode_valid && (opcode == opcode_frame_count);
        end
    end

    assign response = frame_count;

endmodule

// ==== hdl/display_timing.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running raster timing with active-low syncs and a flat fill.
// frame_start pulses together with the vsync falling edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module display_timing import frame_pkg::*; #(
    parameter int h_active = 32,
    parameter int h_total  = 40,
    parameter int v_active = 12,
    parameter int v_total  = 20
) (
    input  logic               clock,
    input  logic               reset,

    input  logic [y_width-1:0] fill_y,
    input  logic [c_width-1:0] fill_cb,
    input  logic [c_width-1:0] fill_cr,
    input  logic               display_enable,

    output logic               display_hsync,
    output logic               display_vsync,
    output logic [y_width-1:0] display_y,
    output logic [c_width-1:0] display_cb,
    output logic [c_width-1:0] display_cr,
    output logic               frame_start
);

    localparam int h_bits      = $clog2(h_total);
    localparam int v_bits      = $clog2(v_total);
    localparam int hsync_width = 4;  // Pixels at the end of each line

    logic [h_bits-1:0] h_count;
    logic [v_bits-1:0] v_count;
    logic              line_end;
    logic              last_line;
    logic              active;

    assign line_end  = (h_count == h_total - 1);
    assign last_line = (v_count == v_total - 1);
    assign active    = (h_count < h_active) && (v_count < v_active);

    always_ff @(posedge clock) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
            v_count <= last_line ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Outputs trail the counters by one clock
    always_ff @(posedge clock) begin
        if (reset) begin
            display_hsync <= 1'b1;
            display_vsync <= 1'b1;
            display_y     <= '0;
            display_cb    <= '0;
            display_cr    <= '0;
            frame_start   <= 1'b0;
        end else begin
            display_hsync <= (h_count < h_total - hsync_width);
            display_vsync <= !last_line;
            frame_start   <= last_line && (h_count == 0);  // First clock of vsync
            if (active && display_enable) begin
                display_y  <= fill_y;
                display_cb <= fill_cb;
                display_cr <= fill_cr;
            end else begin
                display_y  <= '0;
                display_cb <= '0;
                display_cr <= '0;
            end
        end
    end

    counters_in_range: assert property (@(posedge clock) disable iff (reset)
        (h_count < h_total) && (v_count < v_total));

endmodule

// ==== hdl/frame_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcodes, SPI byte type and display pin widths for the display slice.
// Modules pull these in with a wildcard import in their header.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package frame_pkg;

    // One SPI byte, used for opcode, operand and response
    localparam int byte_width = 8;
    typedef logic [byte_width-1:0] byte_t;

    // Host opcodes
    localparam byte_t opcode_chip_id        = 8'hDB; // Read chip ID
    localparam byte_t opcode_fill_colour    = 8'h10; // Y, Cb, Cr operands
    localparam byte_t opcode_display_enable = 8'h11; // Bit 0 of operand 0
    localparam byte_t opcode_frame_count    = 8'h12; // Read frame counter

    localparam byte_t chip_id_value = 8'h81;

    // Display pin widths
    localparam int y_width = 4;
    localparam int c_width = 3;

endpackage

// ==== hdl/spi_peripheral.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mode 0 SPI target oversampled by the system clock. Splits each
// transaction into an opcode and operands and shifts back a response.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module spi_peripheral import frame_pkg::*; (
    input  logic   clock,
    input  logic   reset,

    input  logic   spi_select,
    input  logic   spi_clock,
    input  logic   spi_data_in,
    output logic   spi_data_out,

    output byte_t  opcode,
    output logic   opcode_valid,
    output byte_t  operand,
    output logic   operand_valid,
    output integer operand_count,

    input  byte_t  response_1,
    input  logic   response_1_valid,
    input  byte_t  response_2,
    input  logic   response_2_valid
);

    logic select_meta;
    logic select_sync;
    logic clock_meta;
    logic clock_sync;
    logic clock_prev;
    logic data_meta;
    logic data_sync;
    logic clock_rise;
    logic clock_fall;

    logic [2:0] bit_count;
    byte_t      rx_shift;
    byte_t      rx_byte;
    logic       byte_ready;   // Eighth bit just shifted in
    logic       byte_strobe;  // rx_byte holds a complete byte
    byte_t      tx_shift;
    byte_t      response_byte;

    // Two-flop synchronisers on all pins
    always_ff @(posedge clock) begin
        if (reset) begin
            select_meta <= 1'b1;
            select_sync <= 1'b1;
            clock_meta  <= 1'b0;
            clock_sync  <= 1'b0;
            clock_prev  <= 1'b0;
            data_meta   <= 1'b0;
            data_sync   <= 1'b0;
        end else begin
            select_meta <= spi_select;
            select_sync <= select_meta;
            clock_meta  <= spi_clock;
            clock_sync  <= clock_meta;
            clock_prev  <= clock_sync;
            data_meta   <= spi_data_in;
            data_sync   <= data_meta;
        end
    end

    assign clock_rise = clock_sync & ~clock_prev;
    assign clock_fall = ~clock_sync & clock_prev;

    // Receive shifter, MSB first
    always_ff @(posedge clock) begin
        if (reset || select_sync) begin
            bit_count   <= '0;
            byte_ready  <= 1'b0;
            byte_strobe <= 1'b0;
        end else begin
            byte_ready  <= 1'b0;
            byte_strobe <= byte_ready;
            if (clock_rise) begin
                rx_shift   <= {rx_shift[byte_width-2:0], data_sync};
                bit_count  <= bit_count + 1'b1;  // Wraps to 0 at byte end
                byte_ready <= (bit_count == 3'd7);
            end
            if (byte_ready) begin
                rx_byte <= rx_shift;
            end
        end
    end

    // First byte is the opcode, the rest are operands
    always_ff @(posedge clock) begin
        if (reset || select_sync) begin
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
            operand_count <= 0;
        end else begin
            operand_valid <= 1'b0;
            if (operand_valid) begin
                operand_count <= operand_count + 1;
            end
            if (byte_strobe) begin
                if (!opcode_valid) begin
                    opcode       <= rx_byte;
                    opcode_valid <= 1'b1;
                end else begin
                    operand       <= rx_byte;
                    operand_valid <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        if (response_1_valid) begin
            response_byte = response_1;
        end else if (response_2_valid) begin
            response_byte = response_2;
        end else begin
            response_byte = '0;  // Nobody claims the opcode
        end
    end

    // MISO moves on falling edges; a new response loads at each byte boundary
    always_ff @(posedge clock) begin
        if (reset || select_sync) begin
            spi_data_out <= 1'b0;
            tx_shift     <= '0;
        end else if (clock_fall) begin
            if (bit_count == 3'd0) begin
                spi_data_out <= response_byte[byte_width-1];
                tx_shift     <= response_byte << 1;
            end else begin
                spi_data_out <= tx_shift[byte_width-1];
                tx_shift     <= tx_shift << 1;
            end
        end
    end

    // Responders must decode disjoint opcodes
    one_responder: assert property (@(posedge clock) disable iff (reset)
        !(response_1_valid && response_2_valid));

endmodule

// ==== hdl/spi_register.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-only constant on the SPI bus, returned for one opcode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module spi_register import frame_pkg::*; #(
    parameter byte_t register_address = 8'h00,
    parameter byte_t register_value   = 8'h00
) (
    input  logic  clock,
    input  logic  reset,
    input  byte_t opcode,
    input  logic  opcode_valid,
    output byte_t response,
    output logic  response_valid
);

    assign response = register_value;

    // Registered address match
    always_ff @(posedge clock) begin
        if (reset) begin
            response_valid <= 1'b0;
        end else begin
            response_valid <= opcode_valid && (opcode == register_address);
        end
    end

endmodule

// ==== hdl/top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display controller slice: SPI port, chip ID, display registers and
// timing generator on one clock. Display size is set here.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module top import frame_pkg::*; #(
    parameter int h_active = 32,
    parameter int h_total  = 40,
    parameter int v_active = 12,
    parameter int v_total  = 20
) (
    input  logic               clock,
    input  logic               reset,

    input  logic               spi_select,
    input  logic               spi_clock,
    input  logic               spi_data_in,
    output logic               spi_data_out,

    output logic               display_hsync,
    output logic               display_vsync,
    output logic [y_width-1:0] display_y,
    output logic [c_width-1:0] display_cb,
    output logic [c_width-1:0] display_cr
);

    // Decoded SPI bus
    byte_t  opcode;
    logic   opcode_valid;
    byte_t  operand;
    logic   operand_valid;
    integer operand_count;

    byte_t  response_1;        // Chip ID
    logic   response_1_valid;
    byte_t  response_2;        // Display registers
    logic   response_2_valid;

    logic [y_width-1:0] fill_y;
    logic [c_width-1:0] fill_cb;
    logic [c_width-1:0] fill_cr;
    logic               display_enable;
    logic               frame_start;

    spi_peripheral spi_peripheral (
        .clock(clock),
        .reset(reset),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .operand(operand),
        .operand_valid(operand_valid),
        .operand_count(operand_count),
        .response_1(response_1),
        .response_1_valid(response_1_valid),
        .response_2(response_2),
        .response_2_valid(response_2_valid)
    );

    spi_register #(
        .register_address(opcode_chip_id),
        .register_value(chip_id_value)
    ) chip_id (
        .clock(clock),
        .reset(reset),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .response(response_1),
        .response_valid(response_1_valid)
    );

    display_registers display_registers (
        .clock(clock),
        .reset(reset),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .operand(operand),
        .operand_valid(operand_valid),
        .operand_count(operand_count),
        .frame_start(frame_start),
        .fill_y(fill_y),
        .fill_cb(fill_cb),
        .fill_cr(fill_cr),
        .display_enable(display_enable),
        .response(response_2),
        .response_valid(response_2_valid)
    );

    display_timing #(
        .h_active(h_active),
        .h_total(h_total),
        .v_active(v_active),
        .v_total(v_total)
    ) display_timing (
        .clock(clock),
        .reset(reset),
        .fill_y(fill_y),
        .fill_cb(fill_cb),
        .fill_cr(fill_cr),
        .display_enable(display_enable),
        .display_hsync(display_hsync),
        .display_vsync(display_vsync),
        .display_y(display_y),
        .display_cb(display_cb),
        .display_cr(display_cr),
        .frame_start(frame_start)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the display slice testbench with Verilator and runs it.
# Exits 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --top-module tb_top -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_top > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
fi

if grep -q '^>>> PASS$' "$log_file"; then
    echo "Result: simulation passed"
    exit 0
fi
echo "Result: simulation failed"
exit 1

// ==== testbench/tb_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the display slice: bit-bangs SPI into top and checks
// chip ID, fill colour, enable, sync timing and the frame counter.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_top import frame_pkg::*; ();

    localparam int h_active     = 32;
    localparam int h_total      = 40;
    localparam int v_active     = 12;
    localparam int v_total      = 20;
    localparam int hsync_width  = 4;
    localparam int frame_clocks = h_total * v_total;
    localparam int spi_phase    = 5;   // System clocks per SPI clock phase
    localparam int reset_cycles = 16;
    localparam int pixel_width  = y_width + 2 * c_width;

    logic               clock;
    logic               reset;
    logic               spi_select;
    logic               spi_clock;
    logic               spi_data_in;
    logic               spi_data_out;
    logic               display_hsync;
    logic               display_vsync;
    logic [y_width-1:0] display_y;
    logic [c_width-1:0] display_cb;
    logic [c_width-1:0] display_cr;

    integer seed;
    string  test_name;

    // Expected display configuration, owned by the main sequence
    logic [y_width-1:0] exp_y;
    logic [c_width-1:0] exp_cb;
    logic [c_width-1:0] exp_cr;
    logic               exp_enable;
    logic               monitor_on;

    // Pixel monitor state
    logic                   prev_hsync;
    logic                   prev_vsync;
    logic                   hsync_rise;
    logic                   vsync_rise;
    logic                   locked;      // Raster position known
    int                     h_pos;
    int                     v_pos;
    int                     high_run;    // Clocks since hsync rose
    int                     frames_done;
    logic [pixel_width-1:0] pixel_expected;

    top #(
        .h_active(h_active),
        .h_total(h_total),
        .v_active(v_active),
        .v_total(v_total)
    ) uut (
        .clock(clock),
        .reset(reset),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .display_hsync(display_hsync),
        .display_vsync(display_vsync),
        .display_y(display_y),
        .display_cb(display_cb),
        .display_cr(display_cr)
    );

    always #10 clock = ~clock;

    // Flat fill inside the active area while enabled, black elsewhere
    function automatic logic [pixel_width-1:0] expected_pixel(
        input logic [y_width-1:0] y,
        input logic [c_width-1:0] cb,
        input logic [c_width-1:0] cr,
        input logic               enable,
        input int                 h,
        input int                 v
    );
        if (enable && h < h_active && v < v_active) begin
            return {y, cb, cr};
        end else begin
            return '0;
        end
    endfunction

    task automatic stop_simulation();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic timeout_failure(input string what);
        $display("Timed out waiting for %s", what);
        stop_simulation();
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
            stop_simulation();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
            stop_simulation();
        end
    endtask

    task automatic check_length(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
            stop_simulation();
        end
    endtask

    task automatic check_pixel(
        input string              name,
        input logic [y_width-1:0] exp_y_value,
        input logic [c_width-1:0] exp_cb_value,
        input logic [c_width-1:0] exp_cr_value,
        input logic [y_width-1:0] act_y_value,
        input logic [c_width-1:0] act_cb_value,
        input logic [c_width-1:0] act_cr_value
    );
        if (act_y_value !== exp_y_value || act_cb_value !== exp_cb_value ||
            act_cr_value !== exp_cr_value) begin
            $display("** Error %s: expected y/cb/cr %h/%h/%h, actual %h/%h/%h", name,
                     exp_y_value, exp_cb_value, exp_cr_value,
                     act_y_value, act_cb_value, act_cr_value);
            stop_simulation();
        end
    endtask

    // Inputs move 2 ns after the rising edge
    task automatic wait_clocks(input int count);
        repeat (count) begin
            @(posedge clock);
            #2;
        end
    endtask

    task automatic check_idle_outputs(input string name);
        check_bit({name, " hsync"}, 1'b1, display_hsync);
        check_bit({name, " vsync"}, 1'b1, display_vsync);
        check_pixel({name, " pixel"}, '0, '0, '0, display_y, display_cb, display_cr);
        check_bit({name, " spi_data_out"}, 1'b0, spi_data_out);
    endtask

    // Mode 0 byte, MSB first; MISO sampled just before each rising edge
    task automatic spi_byte(input byte_t tx, output byte_t rx);
        for (int i = byte_width - 1; i >= 0; i--) begin
            spi_data_in = tx[i];
            wait_clocks(spi_phase);
            rx[i] = spi_data_out;
            spi_clock = 1'b1;
            wait_clocks(spi_phase);
            spi_clock = 1'b0;
        end
    endtask

    task automatic spi_begin();
        spi_select = 1'b0;
        wait_clocks(spi_phase);
    endtask

    task automatic spi_end();
        wait_clocks(spi_phase);
        spi_select = 1'b1;
        wait_clocks(2 * spi_phase);  // Let the select reach the synchroniser
    endtask

    task automatic spi_read(input byte_t op, output byte_t value);
        byte_t ignored;
        spi_begin();
        spi_byte(op, ignored);
        spi_byte(8'h00, value);
        spi_end();
    endtask

    task automatic write_fill_colour(input byte_t y, input byte_t cb, input byte_t cr);
        byte_t ignored;
        spi_begin();
        spi_byte(opcode_fill_colour, ignored);
        spi_byte(y, ignored);
        spi_byte(cb, ignored);
        spi_byte(cr, ignored);
        spi_end();
    endtask

    task automatic write_enable(input logic enable);
        byte_t ignored;
        spi_begin();
        spi_byte(opcode_display_enable, ignored);
        spi_byte({7'b0, enable}, ignored);
        spi_end();
    endtask

    task automatic wait_vsync_fall();
        logic prev;
        logic found;
        int   cycles;
        prev   = display_vsync;
        found  = 1'b0;
        cycles = 0;
        while (!found) begin
            wait_clocks(1);
            cycles++;
            found = prev && !display_vsync;
            prev  = display_vsync;
            if (!found && cycles > 2 * frame_clocks) begin
                timeout_failure("a vsync falling edge");
            end
        end
    endtask

    // Monitor checks one whole frame against the expected configuration
    task automatic check_frame(input string name);
        int cycles;
        cycles     = 0;
        test_name  = name;
        monitor_on = 1'b1;
        while (frames_done < 1) begin
            wait_clocks(1);
            cycles++;
            if (cycles > 3 * frame_clocks) begin
                timeout_failure("a full frame of pixels");
            end
        end
        monitor_on = 1'b0;
    endtask

    // The vsync rise marks pixel (0,0); outputs are stable at the falling edge
    always @(negedge clock) begin
        hsync_rise = !prev_hsync && display_hsync;
        vsync_rise = !prev_vsync && display_vsync;
        if (!monitor_on) begin
            locked      = 1'b0;
            frames_done = 0;
        end else begin
            if (vsync_rise) begin
                if (locked) begin
                    frames_done++;
                end
                locked = 1'b1;
                h_pos  = 0;
                v_pos  = 0;
            end else if (hsync_rise) begin
                h_pos = 0;
                v_pos++;
            end else begin
                h_pos++;
            end
            if (hsync_rise) begin
                high_run = 1;
            end else if (display_hsync) begin
                high_run++;
            end
            if (locked) begin
                if (prev_hsync && !display_hsync) begin
                    check_length($sformatf("%s line length at v=%0d", test_name, v_pos),
                                 h_total - hsync_width, high_run);
                end
                pixel_expected = expected_pixel(exp_y, exp_cb, exp_cr, exp_enable,
                                                h_pos, v_pos);
                check_pixel($sformatf("%s pixel at h=%0d v=%0d", test_name, h_pos, v_pos),
                            pixel_expected[pixel_width-1 -: y_width],
                            pixel_expected[2*c_width-1 -: c_width],
                            pixel_expected[c_width-1:0],
                            display_y, display_cb, display_cr);
            end
        end
        prev_hsync = display_hsync;
        prev_vsync = display_vsync;
    end

    initial begin
        byte_t       value;
        byte_t       count_a;
        byte_t       count_b;
        logic [31:0] rand_word;
        int          falls;

        seed        = 32'h3cf1_665d;
        clock       = 1'b0;
        reset       = 1'b1;
        spi_select  = 1'b1;
        spi_clock   = 1'b0;
        spi_data_in = 1'b0;
        monitor_on  = 1'b0;
        exp_y       = '0;
        exp_cb      = '0;
        exp_cr      = '0;
        exp_enable  = 1'b0;
        test_name   = "idle";
        falls       = 3;

        for (int i = 0; i < reset_cycles; i++) begin
            wait_clocks(1);
            check_idle_outputs("reset held");
        end
        reset = 1'b0;
        repeat (4) begin
            wait_clocks(1);
            check_idle_outputs("after reset");
        end

        spi_read(opcode_chip_id, value);
        check_byte("chip id read", 8'h81, value);
        spi_read(8'h55, value);
        check_byte("unused opcode read", 8'h00, value);

        // Upper operand bits are sent too and must be ignored
        rand_word = $random(seed);
        write_fill_colour(rand_word[7:0], rand_word[15:8], rand_word[23:16]);
        write_enable(1'b1);
        exp_y      = rand_word[y_width-1:0];
        exp_cb     = rand_word[8 +: c_width];
        exp_cr     = rand_word[16 +: c_width];
        exp_enable = 1'b1;
        check_frame("fill colour");

        write_enable(1'b0);
        exp_enable = 1'b0;
        check_frame("display disabled");

        wait_vsync_fall();
        spi_read(opcode_frame_count, count_a);
        repeat (falls) begin
            wait_vsync_fall();
        end
        spi_read(opcode_frame_count, count_b);
        check_byte("frame count delta", byte_t'(falls), count_b - count_a);

        $display(">>> PASS");
        $finish;
    end

endmodule
